/* Bender.yml */
package:
  name: write_buffer

sources:
  # Shared types.
  - files:
      - design/wbuf_pkg.sv
  # Synthesizable design.
  - target: rtl
    files:
      - design/write_queue.sv
      - design/cpu_port.sv
      - design/buffer_control.sv
      - design/bus_master.sv
      - design/write_buffer_top.sv
  # Testbench, memory model and bound assertions.
  - target: simulation
    files:
      - dv/bus_memory_model.sv
      - dv/write_buffer_asserts.sv
      - dv/write_buffer_tb.sv

/* compile.f */
design/wbuf_pkg.sv
design/write_queue.sv
design/cpu_port.sv
design/buffer_control.sv
design/bus_master.sv
design/write_buffer_top.sv
dv/bus_memory_model.sv
dv/write_buffer_asserts.sv
dv/write_buffer_tb.sv

/* design/buffer_control.sv */
`timescale 1ns/1ps

module buffer_control (
	input  logic                i_clock,
	input  logic                i_arst_n,
	input  logic                i_pending,
	input  wbuf_pkg::cpu_req_t  i_req,
	input  logic                i_q_full,
	input  logic                i_q_empty,
	input  wbuf_pkg::wq_entry_t i_q_head,
	input  logic                i_bus_busy,
	input  logic                i_bus_done,
	input  wbuf_pkg::data_t     i_bus_rdata,
	output logic                o_accept,
	output logic                o_read_done,
	output wbuf_pkg::data_t     o_read_data,
	output logic                o_push,
	output wbuf_pkg::wq_entry_t o_entry,
	output logic                o_pop,
	output logic                o_bus_start,
	output wbuf_pkg::bus_req_t  o_bus_req
);

	import wbuf_pkg::*;

	ctrl_state_e state;
	ctrl_state_e next_state;

	logic write_admit;
	logic drain_start;
	logic read_start;

	// Writes are admitted alongside draining, never during a read.
	assign write_admit = (state != ST_READ) && i_pending && i_req.rw && !i_q_full;

	// Draining owns the bus whenever the queue holds something.
	assign drain_start = !i_q_empty && !i_bus_busy;

	// A read goes out only once every earlier write has left the buffer.
	assign read_start = (state != ST_READ) && i_pending && !i_req.rw &&
		i_q_empty && !i_bus_busy;

	assign o_push  = write_admit;
	assign o_entry = '{address: i_req.address, data: i_req.wdata};
	assign o_accept = write_admit;

	assign o_pop       = drain_start;
	assign o_bus_start = drain_start || read_start;

	always_comb begin
		if (drain_start) begin
			o_bus_req = '{rw: 1'b1, address: i_q_head.address, wdata: i_q_head.data};
		end else begin
			o_bus_req = '{rw: 1'b0, address: i_req.address, wdata: '0};
		end
	end

	assign o_read_done = (state == ST_READ) && i_bus_done;
	assign o_read_data = i_bus_rdata;

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE, ST_DRAIN: begin
				if (read_start) begin
					next_state = ST_READ;
				end else if (!i_q_empty || i_bus_busy || write_admit) begin
					next_state = ST_DRAIN;  // Writes still outstanding.
				end else begin
					next_state = ST_IDLE;
				end
			end
			ST_READ: begin
				if (i_bus_done) begin
					next_state = i_q_empty ? ST_IDLE : ST_DRAIN;
				end
			end
			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

endmodule

/* design/bus_master.sv */
`timescale 1ns/1ps

module bus_master (
	input  logic               i_clock,
	input  logic               i_arst_n,
	input  logic               i_start,
	input  wbuf_pkg::bus_req_t i_req,
	input  logic               i_bus_ready,
	input  wbuf_pkg::data_t    i_bus_rdata,
	output logic               o_busy,
	output logic               o_done,
	output wbuf_pkg::data_t    o_rdata,
	output logic               o_bus_request,
	output logic               o_bus_rw,
	output wbuf_pkg::addr_t    o_bus_address,
	output wbuf_pkg::data_t    o_bus_wdata
);

	import wbuf_pkg::*;

	bus_req_t req_q;
	data_t    rdata_q;
	logic     request_q;
	logic     done_q;
	logic     complete;

	assign complete = request_q && i_bus_ready;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			request_q <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			done_q <= complete;
			if (i_start) begin
				request_q <= 1'b1;
			end else if (complete) begin
				request_q <= 1'b0;  // Dropped the cycle after ready.
			end
		end
	end

	// Fields stay put for as long as the request is held.
	always_ff @(posedge i_clock) begin
		if (i_start) begin
			req_q <= i_req;
		end
	end

	always_ff @(posedge i_clock) begin
		if (complete) begin
			rdata_q <= i_bus_rdata;
		end
	end

	assign o_busy        = request_q;
	assign o_done        = done_q;
	assign o_rdata       = rdata_q;
	assign o_bus_request = request_q;
	assign o_bus_rw      = req_q.rw;
	assign o_bus_address = req_q.address;
	assign o_bus_wdata   = req_q.wdata;

endmodule

/* design/cpu_port.sv */
`timescale 1ns/1ps

module cpu_port (
	input  logic               i_clock,
	input  logic               i_arst_n,
	input  logic               i_request,
	input  logic               i_rw,
	input  wbuf_pkg::addr_t    i_address,
	input  wbuf_pkg::data_t    i_wdata,
	input  logic               i_accept,
	input  logic               i_read_done,
	input  wbuf_pkg::data_t    i_read_data,
	output logic               o_pending,
	output wbuf_pkg::cpu_req_t o_req,
	output logic               o_ready,
	output wbuf_pkg::data_t    o_rdata
);

	import wbuf_pkg::*;

	cpu_req_t req_q;
	data_t    rdata_q;
	logic     pending_q;
	logic     ready_q;
	logic     take;
	logic     finish;

	// A request still held while ready is high has already been served.
	assign take   = i_request && !pending_q && !ready_q;
	assign finish = i_accept || i_read_done;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pending_q <= 1'b0;
			ready_q   <= 1'b0;
		end else begin
			ready_q <= finish;  // One-cycle pulse.
			if (finish) begin
				pending_q <= 1'b0;
			end else if (take) begin
				pending_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (take) begin
			req_q <= '{rw: i_rw, address: i_address, wdata: i_wdata};
		end
	end

	// Read data lines up with the ready pulse.
	always_ff @(posedge i_clock) begin
		if (i_read_done) begin
			rdata_q <= i_read_data;
		end
	end

	assign o_pending = pending_q;
	assign o_req     = req_q;
	assign o_ready   = ready_q;
	assign o_rdata   = rdata_q;

endmodule

/* design/wbuf_pkg.sv */
package wbuf_pkg;

	// Bus byte address and data word.
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// Processor request as held by the input port.
	typedef struct packed {
		logic  rw;      // 1 means write.
		addr_t address;
		data_t wdata;
	} cpu_req_t;

	// One posted write waiting in the queue.
	typedef struct packed {
		addr_t address;
		data_t data;
	} wq_entry_t;

	// One bus transaction.
	typedef struct packed {
		logic  rw;      // 1 means write.
		addr_t address;
		data_t wdata;
	} bus_req_t;

	// Controller states.
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DRAIN,
		ST_READ
	} ctrl_state_e;

endpackage

/* design/write_buffer_top.sv */
`timescale 1ns/1ps

module write_buffer_top #(
	parameter int QUEUE_DEPTH = 8  // Power of two, at least 2.
) (
	input  logic            i_clock,
	input  logic            i_arst_n,
	input  logic            i_request,
	input  logic            i_rw,
	input  wbuf_pkg::addr_t i_address,
	input  wbuf_pkg::data_t i_wdata,
	output logic            o_ready,
	output wbuf_pkg::data_t o_rdata,
	output logic            o_bus_request,
	output logic            o_bus_rw,
	output wbuf_pkg::addr_t o_bus_address,
	output wbuf_pkg::data_t o_bus_wdata,
	input  logic            i_bus_ready,
	input  wbuf_pkg::data_t i_bus_rdata
);

	import wbuf_pkg::*;

	logic      pending;
	cpu_req_t  cpu_req;
	logic      accept;
	logic      read_done;
	data_t     read_data;
	logic      q_push;
	logic      q_pop;
	wq_entry_t q_entry;
	wq_entry_t q_head;
	logic      q_full;
	logic      q_empty;
	logic      bus_start;
	bus_req_t  bus_req;
	logic      bus_busy;
	logic      bus_done;
	data_t     bus_rdata;

	cpu_port cpu_port_i (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_request(i_request), .i_rw(i_rw), .i_address(i_address), .i_wdata(i_wdata),
		.i_accept(accept), .i_read_done(read_done), .i_read_data(read_data),
		.o_pending(pending), .o_req(cpu_req), .o_ready(o_ready), .o_rdata(o_rdata)
	);

	buffer_control buffer_control_i (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_pending(pending), .i_req(cpu_req),
		.i_q_full(q_full), .i_q_empty(q_empty), .i_q_head(q_head),
		.i_bus_busy(bus_busy), .i_bus_done(bus_done), .i_bus_rdata(bus_rdata),
		.o_accept(accept), .o_read_done(read_done), .o_read_data(read_data),
		.o_push(q_push), .o_entry(q_entry), .o_pop(q_pop),
		.o_bus_start(bus_start), .o_bus_req(bus_req)
	);

	write_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) write_queue_i (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_push(q_push), .i_entry(q_entry), .i_pop(q_pop),
		.o_head(q_head), .o_full(q_full), .o_empty(q_empty)
	);

	bus_master bus_master_i (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_start(bus_start), .i_req(bus_req),
		.i_bus_ready(i_bus_ready), .i_bus_rdata(i_bus_rdata),
		.o_busy(bus_busy), .o_done(bus_done), .o_rdata(bus_rdata),
		.o_bus_request(o_bus_request), .o_bus_rw(o_bus_rw),
		.o_bus_address(o_bus_address), .o_bus_wdata(o_bus_wdata)
	);

endmodule

/* design/write_queue.sv */
`timescale 1ns/1ps

module write_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                i_clock,
	input  logic                i_arst_n,
	input  logic                i_push,
	input  wbuf_pkg::wq_entry_t i_entry,
	input  logic                i_pop,
	output wbuf_pkg::wq_entry_t o_head,
	output logic                o_full,
	output logic                o_empty
);

	import wbuf_pkg::*;

	localparam int IDX_W = $clog2(QUEUE_DEPTH);

	wq_entry_t mem [QUEUE_DEPTH];

	// One extra bit tells a full queue from an empty one.
	logic [IDX_W:0] wr_ptr;
	logic [IDX_W:0] rd_ptr;

	logic do_push;
	logic do_pop;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) &&
		(wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);

	// The pop frees a slot first, so a push into a full queue may pair with it.
	assign do_pop  = i_pop && !o_empty;
	assign do_push = i_push && (!o_full || do_pop);

	assign o_head = mem[rd_ptr[IDX_W-1:0]];

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (do_push) begin
			mem[wr_ptr[IDX_W-1:0]] <= i_entry;
		end
	end

endmodule

/* dv/bus_memory_model.sv */
`timescale 1ns/1ps

module bus_memory_model #(
	parameter int unsigned SEED = 1
) (
	input  logic            i_clock,
	input  logic            i_hold,
	input  logic            i_bus_request,
	input  logic            i_bus_rw,
	input  wbuf_pkg::addr_t i_bus_address,
	input  wbuf_pkg::data_t i_bus_wdata,
	output logic            o_bus_ready,
	output wbuf_pkg::data_t o_bus_rdata
);

	import wbuf_pkg::*;

	data_t       mem [addr_t];
	wq_entry_t   write_log [$];  // Writes in the order they reached the bus.
	int unsigned delay;
	logic        waiting;

	function automatic data_t read_word(input addr_t address);
		if (mem.exists(address)) begin
			return mem[address];
		end
		return address ^ 32'hc3a5_5a3c;  // Unwritten words follow the address.
	endfunction

	initial begin
		void'($urandom(SEED));
		o_bus_ready = 1'b0;
		o_bus_rdata = '0;
		waiting     = 1'b0;
		delay       = 0;
		forever begin
			@(negedge i_clock);
			o_bus_ready = 1'b0;  // Ready is a one-cycle strobe.
			if (i_bus_request) begin
				if (!waiting) begin
					delay   = $urandom % 4;  // New transaction.
					waiting = 1'b1;
				end
				if (!i_hold && delay == 0) begin
					o_bus_ready = 1'b1;
					waiting     = 1'b0;
					if (i_bus_rw) begin
						mem[i_bus_address] = i_bus_wdata;
						write_log.push_back('{address: i_bus_address, data: i_bus_wdata});
					end else begin
						o_bus_rdata = read_word(i_bus_address);
					end
				end else if (!i_hold) begin
					delay--;
				end
			end
		end
	end

endmodule

/* dv/write_buffer_asserts.sv */
`timescale 1ns/1ps

module write_buffer_asserts (
	input logic            i_clock,
	input logic            i_arst_n,
	input logic            i_ready,
	input logic            i_bus_request,
	input logic            i_bus_rw,
	input wbuf_pkg::addr_t i_bus_address,
	input wbuf_pkg::data_t i_bus_wdata,
	input logic            i_bus_ready
);

	int unsigned fail_count = 0;  // Failed assertions so far.

	// A request without ready stays on the bus unchanged.
	bus_hold_a: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(i_bus_request && !i_bus_ready) |=> (i_bus_request && $stable(i_bus_rw) &&
		$stable(i_bus_address) && $stable(i_bus_wdata)))
	else begin
		fail_count++;
		$error("Bus fields changed while the request waited for ready.");
	end

	ready_pulse_a: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_ready |=> !i_ready)
	else begin
		fail_count++;
		$error("Processor ready stayed high for two cycles in a row.");
	end

endmodule

bind write_buffer_top write_buffer_asserts write_buffer_asserts_i (
	.i_clock(i_clock), .i_arst_n(i_arst_n), .i_ready(o_ready),
	.i_bus_request(o_bus_request), .i_bus_rw(o_bus_rw),
	.i_bus_address(o_bus_address), .i_bus_wdata(o_bus_wdata),
	.i_bus_ready(i_bus_ready)
);

/* dv/write_buffer_tb.sv */
`timescale 1ns/1ps

module write_buffer_tb;

	import wbuf_pkg::*;

	localparam int          QUEUE_DEPTH = 4;
	localparam int          WAIT_LIMIT  = 100;
	localparam int          STALL_LIMIT = 30;  // No accept for this long means full.
	localparam int unsigned SEED        = 32'h9d47d645;
	localparam int          NUM_OPS     = 12;

	typedef struct packed {
		logic  rw;
		addr_t address;
		data_t wdata;
		data_t exp_rdata;  // Reads only.
	} op_t;

	logic  clock;
	logic  arst_n;
	logic  request;
	logic  rw;
	addr_t address;
	data_t wdata;
	logic  ready;
	data_t rdata;
	logic  bus_request;
	logic  bus_rw;
	addr_t bus_address;
	data_t bus_wdata;
	logic  bus_ready;
	data_t bus_rdata;
	logic  hold;

	data_t     ref_mem [addr_t];
	wq_entry_t exp_log [$];

	// Rows 4 to 8 are a burst to one address followed by a read.
	op_t ops [NUM_OPS] = '{
		'{1'b1, 32'h0000_0100, 32'h1111_0001, 32'h0},
		'{1'b1, 32'h0000_0104, 32'h2222_0002, 32'h0},
		'{1'b0, 32'h0000_0100, 32'h0, 32'h1111_0001},
		'{1'b0, 32'h0000_0104, 32'h0, 32'h2222_0002},
		'{1'b1, 32'h0000_0200, 32'haaaa_0001, 32'h0},
		'{1'b1, 32'h0000_0200, 32'haaaa_0002, 32'h0},
		'{1'b1, 32'h0000_0200, 32'haaaa_0003, 32'h0},
		'{1'b1, 32'h0000_0200, 32'haaaa_0004, 32'h0},
		'{1'b0, 32'h0000_0200, 32'h0, 32'haaaa_0004},
		'{1'b1, 32'h0000_0100, 32'h3333_0003, 32'h0},
		'{1'b1, 32'h0000_0104, 32'h4444_0004, 32'h0},
		'{1'b0, 32'h0000_0100, 32'h0, 32'h3333_0003}
	};

	write_buffer_top #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) write_buffer_top_i (
		.i_clock(clock), .i_arst_n(arst_n),
		.i_request(request), .i_rw(rw), .i_address(address), .i_wdata(wdata),
		.o_ready(ready), .o_rdata(rdata),
		.o_bus_request(bus_request), .o_bus_rw(bus_rw),
		.o_bus_address(bus_address), .o_bus_wdata(bus_wdata),
		.i_bus_ready(bus_ready), .i_bus_rdata(bus_rdata)
	);

	bus_memory_model #(
		.SEED(SEED)
	) memory_i (
		.i_clock(clock), .i_hold(hold),
		.i_bus_request(bus_request), .i_bus_rw(bus_rw),
		.i_bus_address(bus_address), .i_bus_wdata(bus_wdata),
		.o_bus_ready(bus_ready), .o_bus_rdata(bus_rdata)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(write_buffer_top_i.write_buffer_asserts_i.fail_count) begin
		if (write_buffer_top_i.write_buffer_asserts_i.fail_count != 0) begin
			$display("A protocol assertion failed during the run.");
			$display("test failed");
			$fatal(1, "Stopped on an assertion failure.");
		end
	end

	task automatic check_value(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1, "Stopped at the first mismatch.");
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout while waiting for %s after %0d cycles.", what, WAIT_LIMIT);
		$display("test failed");
		$fatal(1, "Stopped on a timeout.");
	endtask

	// Ends at the falling edge inside the ready cycle, or gives up.
	task automatic wait_ready(input int max_cycles, output bit seen);
		int count;
		seen  = 1'b0;
		count = 0;
		while (!seen && count < max_cycles) begin
			@(negedge clock);
			seen = ready;
			count++;
		end
	endtask

	task automatic note_write(input addr_t a, input data_t d);
		ref_mem[a] = d;
		exp_log.push_back('{address: a, data: d});
	endtask

	task automatic run_op(input op_t op, input string name);
		bit seen;
		request = 1'b1;
		rw      = op.rw;
		address = op.address;
		wdata   = op.wdata;
		wait_ready(WAIT_LIMIT, seen);
		if (!seen) begin
			stop_on_timeout({"ready of ", name});
		end
		if (op.rw) begin
			note_write(op.address, op.wdata);
		end else begin
			check_value(name, op.exp_rdata, rdata);
			check_value({name, " against reference memory"}, ref_mem[op.address], rdata);
		end
		@(negedge clock);
		request = 1'b0;
	endtask

	task automatic check_write_log();
		check_value("write log size", exp_log.size(), memory_i.write_log.size());
		foreach (exp_log[k]) begin
			check_value($sformatf("write log %0d address", k), exp_log[k].address,
				memory_i.write_log[k].address);
			check_value($sformatf("write log %0d data", k), exp_log[k].data,
				memory_i.write_log[k].data);
		end
	endtask

	initial begin
		int  accepted;
		bit  seen;
		bit  stalled;
		op_t last_read;
		arst_n  = 1'b0;
		request = 1'b0;
		rw      = 1'b0;
		address = '0;
		wdata   = '0;
		hold    = 1'b0;
		@(posedge clock);
		repeat (10) begin
			@(negedge clock);
			check_value("ready during reset", 0, ready);
			check_value("bus request during reset", 0, bus_request);
		end
		arst_n = 1'b1;
		repeat (2) begin
			@(negedge clock);
			check_value("ready after reset", 0, ready);
			check_value("bus request after reset", 0, bus_request);
		end
		for (int i = 0; i < NUM_OPS; i++) begin
			run_op(ops[i], $sformatf("row %0d", i));
		end
		check_write_log();
		// The bus stalls, so the queue and the bus master fill up.
		hold     = 1'b1;
		accepted = 0;
		stalled  = 1'b0;
		while (!stalled && accepted <= 2 * QUEUE_DEPTH) begin
			request = 1'b1;
			rw      = 1'b1;
			address = 32'h0000_0400 + 4 * accepted;
			wdata   = 32'hbeef_0000 + accepted;
			wait_ready(STALL_LIMIT, seen);
			if (seen) begin
				note_write(address, wdata);
				accepted++;
				@(negedge clock);
			end else begin
				stalled = 1'b1;
			end
		end
		check_value("accepted writes while the bus is held", QUEUE_DEPTH + 1, accepted);
		hold = 1'b0;
		wait_ready(WAIT_LIMIT, seen);
		if (!seen) begin
			stop_on_timeout("the write held back by the full buffer");
		end
		note_write(address, wdata);
		@(negedge clock);
		request             = 1'b0;
		last_read.rw        = 1'b0;
		last_read.address   = address;
		last_read.wdata     = '0;
		last_read.exp_rdata = wdata;
		run_op(last_read, "read after release");
		check_write_log();
		$display("test passed");
		$finish;
	end

endmodule
